// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_icrc_insert
FILELIST  ?= icrc_insert.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	-$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "STATUS: PASS" $(LOG); then echo "simulation ended early"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== icrc_append.sv ====
`timescale 1ns/1ps
`include "icrc_defs.svh"

module icrc_append
  import icrc_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  axis_beat_t s_beat,
  input  logic       s_valid,
  output logic       s_ready,
  output axis_beat_t buf_beat,
  output logic       buf_valid,
  input  logic       buf_ready_early,
  output logic       busy
);

  localparam int MERGE_W = `ICRC_DATA_W + 8 * `ICRC_BYTES;

  append_state_t state, state_next;
  logic s_ready_reg, s_ready_next;
  logic buf_ready_reg;
  logic busy_reg;
  logic fire;
  byte_cnt_t byte_cnt;
  data_t data_mask;
  crc_t crc_next;
  crc_t icrc;
  logic [MERGE_W-1:0] merged;
  axis_beat_t tail_reg, tail_next;
  logic tail_load;

  function automatic keep_t count_to_keep(input byte_cnt_t cnt);
    keep_t k;
    for (int i = 0; i < `ICRC_KEEP_W; i++) begin
      k[i] = (i < cnt);
    end
    return k;
  endfunction

  assign s_ready = s_ready_reg;
  assign busy    = busy_reg;
  assign fire    = s_valid && s_ready_reg;

  icrc_crc_accum u_crc (
    .clk       (clk),
    .rst       (rst),
    .beat_fire (fire),
    .frame_end (s_beat.last),
    .beat_data (s_beat.data),
    .beat_keep (s_beat.keep),
    .crc_next  (crc_next)
  );

  always_comb begin
    byte_cnt = '0;
    for (int i = 0; i < `ICRC_KEEP_W; i++) begin
      byte_cnt = byte_cnt + byte_cnt_t'(s_beat.keep[i]);
      data_mask[8*i +: 8] = {8{s_beat.keep[i]}};
    end
  end

  // icrc lands right after byte n-1 and its upper part spills to the tail
  assign icrc   = ~crc_next;
  assign merged = {{(8*`ICRC_BYTES){1'b0}}, s_beat.data & data_mask} |
                  ({{`ICRC_DATA_W{1'b0}}, icrc} << {byte_cnt, 3'b000});

  always_comb begin
    tail_next.data = {{(`ICRC_DATA_W-8*`ICRC_BYTES){1'b0}}, merged[MERGE_W-1:`ICRC_DATA_W]};
    tail_next.keep = count_to_keep(byte_cnt - byte_cnt_t'(`ICRC_BYTES));
    tail_next.last = 1'b1;
    tail_next.user = 1'b0;
  end

  always_comb begin
    state_next    = state;
    s_ready_next  = buf_ready_early;
    tail_load     = 1'b0;
    buf_beat      = s_beat;
    buf_beat.user = 1'b0;
    buf_valid     = fire;
    case (state)
      ST_IDLE, ST_PAYLOAD: begin
        if (fire) begin
          if (!s_beat.last) begin
            state_next = ST_PAYLOAD;
          end else if (s_beat.user) begin
            // errored frame goes out as is
            buf_beat.user = 1'b1;
            state_next    = ST_IDLE;
          end else begin
            buf_beat.data = merged[`ICRC_DATA_W-1:0];
            if (byte_cnt > byte_cnt_t'(`ICRC_BYTES)) begin
              buf_beat.keep = '1;
              buf_beat.last = 1'b0;
              tail_load     = 1'b1;
              s_ready_next  = 1'b0;
              state_next    = ST_TAIL;
            end else begin
              buf_beat.keep = count_to_keep(byte_cnt + byte_cnt_t'(`ICRC_BYTES));
              state_next    = ST_IDLE;
            end
          end
        end
      end
      ST_TAIL: begin
        buf_beat     = tail_reg;
        buf_valid    = 1'b1;
        s_ready_next = 1'b0;
        if (buf_ready_reg) begin
          s_ready_next = buf_ready_early;
          state_next   = ST_IDLE;
        end
      end
      default: begin
        state_next = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state         <= ST_IDLE;
      s_ready_reg   <= 1'b0;
      buf_ready_reg <= 1'b0;
      busy_reg      <= 1'b0;
    end else begin
      state         <= state_next;
      s_ready_reg   <= s_ready_next;
      buf_ready_reg <= buf_ready_early;
      busy_reg      <= (state_next != ST_IDLE);
    end
  end

  always_ff @(posedge clk) begin
    if (tail_load) begin
      tail_reg <= tail_next;
    end
  end

  assert property (@(posedge clk) disable iff (rst)
    s_valid |-> ((s_beat.keep + 1'b1) & s_beat.keep) == '0);

  assert property (@(posedge clk) disable iff (rst)
    s_valid && !s_beat.last |-> s_beat.keep == '1);

  assert property (@(posedge clk) disable iff (rst)
    state == ST_TAIL |-> !s_ready);

endmodule

// ==== icrc_crc_accum.sv ====
`timescale 1ns/1ps
`include "icrc_defs.svh"

module icrc_crc_accum
  import icrc_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  logic  beat_fire,
  input  logic  frame_end,
  input  data_t beat_data,
  input  keep_t beat_keep,
  output crc_t  crc_next
);

  crc_t crc_reg;
  crc_t crc_work;

  // bytes from 0 upward with each byte lsb first
  always_comb begin
    crc_work = crc_reg;
    for (int i = 0; i < `ICRC_KEEP_W; i++) begin
      if (beat_keep[i]) begin
        for (int j = 0; j < 8; j++) begin
          if (crc_work[0] ^ beat_data[8*i+j]) begin
            crc_work = {1'b0, crc_work[31:1]} ^ `ICRC_CRC_POLY;
          end else begin
            crc_work = {1'b0, crc_work[31:1]};
          end
        end
      end
    end
  end

  assign crc_next = crc_work;

  always_ff @(posedge clk) begin
    if (rst) begin
      crc_reg <= `ICRC_CRC_INIT;
    end else if (beat_fire) begin
      // errored frames restart the crc as well
      if (frame_end) begin
        crc_reg <= `ICRC_CRC_INIT;
      end else begin
        crc_reg <= crc_next;
      end
    end
  end

endmodule

// ==== icrc_defs.svh ====
`ifndef ICRC_DEFS_SVH
`define ICRC_DEFS_SVH

// beat geometry
`define ICRC_DATA_W 64
`define ICRC_KEEP_W 8

// reflected crc-32 as used by the RoCEv2 ICRC
`define ICRC_CRC_POLY 32'hEDB88320
`define ICRC_CRC_INIT 32'hFFFFFFFF

`define ICRC_BYTES 4

`endif

// ==== icrc_insert.f ====
+incdir+.
icrc_pkg.sv
icrc_crc_accum.sv
icrc_append.sv
icrc_out_buf.sv
icrc_insert_top.sv
tb_icrc_insert.sv

// ==== icrc_insert_top.sv ====
`timescale 1ns/1ps
`include "icrc_defs.svh"

module icrc_insert_top
  import icrc_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  axis_beat_t s_beat,
  input  logic       s_valid,
  output logic       s_ready,
  output axis_beat_t m_beat,
  output logic       m_valid,
  input  logic       m_ready,
  output logic       busy
);

  // framing stage to skid buffer
  axis_beat_t buf_beat;
  logic       buf_valid;
  logic       buf_ready_early;

  icrc_append u_append (
    .clk             (clk),
    .rst             (rst),
    .s_beat          (s_beat),
    .s_valid         (s_valid),
    .s_ready         (s_ready),
    .buf_beat        (buf_beat),
    .buf_valid       (buf_valid),
    .buf_ready_early (buf_ready_early),
    .busy            (busy)
  );

  icrc_out_buf u_out_buf (
    .clk            (clk),
    .rst            (rst),
    .in_beat        (buf_beat),
    .in_valid       (buf_valid),
    .in_ready_early (buf_ready_early),
    .m_beat         (m_beat),
    .m_valid        (m_valid),
    .m_ready        (m_ready)
  );

endmodule

// ==== icrc_out_buf.sv ====
`timescale 1ns/1ps
`include "icrc_defs.svh"

module icrc_out_buf
  import icrc_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  axis_beat_t in_beat,
  input  logic       in_valid,
  output logic       in_ready_early,
  output axis_beat_t m_beat,
  output logic       m_valid,
  input  logic       m_ready
);

  axis_beat_t out_reg;
  axis_beat_t temp_reg;
  logic out_valid, out_valid_next;
  logic temp_valid, temp_valid_next;
  logic in_ready_reg;
  logic store_in_to_out;
  logic store_in_to_temp;
  logic store_temp_to_out;

  assign m_beat  = out_reg;
  assign m_valid = out_valid;

  // room next cycle if the output drains or nothing is held
  assign in_ready_early = m_ready || (!out_valid && !temp_valid);

  always_comb begin
    out_valid_next    = out_valid;
    temp_valid_next   = temp_valid;
    store_in_to_out   = 1'b0;
    store_in_to_temp  = 1'b0;
    store_temp_to_out = 1'b0;
    if (in_ready_reg) begin
      if (m_ready || !out_valid) begin
        out_valid_next  = in_valid;
        store_in_to_out = 1'b1;
      end else begin
        // park the beat in the skid register while the output stalls
        temp_valid_next  = in_valid;
        store_in_to_temp = 1'b1;
      end
    end else if (m_ready) begin
      out_valid_next    = temp_valid;
      temp_valid_next   = 1'b0;
      store_temp_to_out = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid    <= 1'b0;
      temp_valid   <= 1'b0;
      in_ready_reg <= 1'b0;
    end else begin
      out_valid    <= out_valid_next;
      temp_valid   <= temp_valid_next;
      in_ready_reg <= in_ready_early;
    end
  end

  always_ff @(posedge clk) begin
    if (store_in_to_out) begin
      out_reg <= in_beat;
    end else if (store_temp_to_out) begin
      out_reg <= temp_reg;
    end
    if (store_in_to_temp) begin
      temp_reg <= in_beat;
    end
  end

  assert property (@(posedge clk) disable iff (rst)
    m_valid && !m_ready |=> m_valid && $stable(m_beat));

endmodule

// ==== icrc_pkg.sv ====
`include "icrc_defs.svh"

package icrc_pkg;

  typedef logic [`ICRC_DATA_W-1:0] data_t;
  typedef logic [`ICRC_KEEP_W-1:0] keep_t;
  typedef logic [31:0] crc_t;
  typedef logic [$clog2(`ICRC_KEEP_W+1)-1:0] byte_cnt_t;

  // one stream beat where user on last marks an errored frame
  typedef struct packed {
    data_t data;
    keep_t keep;
    logic  last;
    logic  user;
  } axis_beat_t;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_PAYLOAD,
    ST_TAIL
  } append_state_t;

endpackage

// ==== tb_icrc_insert.sv ====
`timescale 1ns/1ps
`include "icrc_defs.svh"

module tb_icrc_insert
  import icrc_pkg::*;
();

  // longest run is well under 300 cycles even with every output stalled half the time
  localparam int MAX_CYCLES = 2000;
  localparam int WAIT_LIMIT = 400;

  logic       clk;
  logic       rst;
  axis_beat_t s_beat;
  logic       s_valid;
  logic       s_ready;
  axis_beat_t m_beat;
  logic       m_valid;
  logic       m_ready = 1'b1;
  logic       busy;

  axis_beat_t in_q[$];
  axis_beat_t exp_q[$];
  axis_beat_t got_q[$];
  logic [7:0] work_bytes[$];
  logic [31:0] payload_rng = 32'd45;
  logic [31:0] ready_rng = 32'd45;
  logic stall_en = 1'b0;
  crc_t last_icrc;
  int cycle_count = 0;
  int busy_hits = 0;
  int errors = 0;
  int tests_passed = 0;
  int tests_failed = 0;

  icrc_insert_top UUT (
    .clk     (clk),
    .rst     (rst),
    .s_beat  (s_beat),
    .s_valid (s_valid),
    .s_ready (s_ready),
    .m_beat  (m_beat),
    .m_valid (m_valid),
    .m_ready (m_ready),
    .busy    (busy)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_payload();
    payload_rng = xorshift32(payload_rng);
    return payload_rng;
  endfunction

  // bitwise reflected crc-32 model fed one byte at a time
  function automatic crc_t crc_byte(input crc_t c, input logic [7:0] b);
    crc_t r;
    r = c ^ {24'h0, b};
    for (int k = 0; k < 8; k++) begin
      if (r[0]) begin
        r = (r >> 1) ^ `ICRC_CRC_POLY;
      end else begin
        r = r >> 1;
      end
    end
    return r;
  endfunction

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  always @(posedge clk) begin
    if (stall_en) begin
      ready_rng = xorshift32(ready_rng);
      m_ready <= ready_rng[4];
    end else begin
      m_ready <= 1'b1;
    end
  end

  always @(posedge clk) begin
    if (!rst && m_valid && m_ready) begin
      got_q.push_back(m_beat);
    end
    if (busy) begin
      busy_hits <= busy_hits + 1;
    end
  end

  task automatic check_beat(input string name, input axis_beat_t exp, input axis_beat_t got);
    data_t mask;
    for (int i = 0; i < `ICRC_KEEP_W; i++) begin
      mask[8*i +: 8] = {8{exp.keep[i]}};
    end
    if ((exp.data & mask) !== (got.data & mask) || exp.keep !== got.keep ||
        exp.last !== got.last || exp.user !== got.user) begin
      $write("FAIL %s: expected data %h keep %b last %b user %b,",
             name, exp.data & mask, exp.keep, exp.last, exp.user);
      $display(" actual data %h keep %b last %b user %b",
               got.data & mask, got.keep, got.last, got.user);
      errors++;
    end
  endtask

  task automatic check_crc(input string name, input crc_t exp, input crc_t got);
    if (exp !== got) begin
      $display("FAIL %s: expected %h actual %h", name, exp, got);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic got);
    if (exp !== got) begin
      $display("FAIL %s: expected %b actual %b", name, exp, got);
      errors++;
    end
  endtask

  // cut work_bytes into beats with junk in the unused byte lanes
  task automatic chunk_bytes(input logic to_input, input logic err);
    axis_beat_t b;
    int n;
    int pos;
    pos = 0;
    while (pos < work_bytes.size()) begin
      n = work_bytes.size() - pos;
      if (n > `ICRC_KEEP_W) begin
        n = `ICRC_KEEP_W;
      end
      b.data = {next_payload(), next_payload()};
      b.keep = '0;
      for (int i = 0; i < n; i++) begin
        b.data[8*i +: 8] = work_bytes[pos+i];
        b.keep[i] = 1'b1;
      end
      pos = pos + n;
      b.last = (pos == work_bytes.size());
      b.user = b.last && err;
      if (to_input) begin
        in_q.push_back(b);
      end else begin
        exp_q.push_back(b);
      end
    end
  endtask

  task automatic add_frame(input int len, input logic err);
    crc_t crc;
    crc = `ICRC_CRC_INIT;
    work_bytes.delete();
    for (int i = 0; i < len; i++) begin
      work_bytes.push_back(8'(next_payload()));
      crc = crc_byte(crc, work_bytes[i]);
    end
    last_icrc = ~crc;
    chunk_bytes(1'b1, err);
    if (!err) begin
      for (int i = 0; i < `ICRC_BYTES; i++) begin
        work_bytes.push_back(last_icrc[8*i +: 8]);
      end
    end
    chunk_bytes(1'b0, err);
  endtask

  task automatic drive_input();
    axis_beat_t b;
    while (in_q.size() > 0) begin
      b = in_q.pop_front();
      s_beat  <= b;
      s_valid <= 1'b1;
      do @(posedge clk); while (!s_ready);
    end
    s_valid <= 1'b0;
  endtask

  task automatic collect_outputs(input string name);
    int waited;
    waited = 0;
    while (got_q.size() < exp_q.size() && waited < WAIT_LIMIT) begin
      @(posedge clk);
      waited++;
    end
    repeat (4) @(posedge clk);
    if (got_q.size() < exp_q.size()) begin
      $display("%s: only %0d of %0d output beats arrived", name, got_q.size(), exp_q.size());
      errors++;
    end else if (got_q.size() > exp_q.size()) begin
      $display("%s: %0d unexpected extra output beats", name, got_q.size() - exp_q.size());
      errors++;
    end
    for (int i = 0; i < exp_q.size() && i < got_q.size(); i++) begin
      check_beat(name, exp_q[i], got_q[i]);
    end
  endtask

  task automatic start_test(output int err0);
    in_q.delete();
    exp_q.delete();
    got_q.delete();
    err0 = errors;
    @(posedge clk);
  endtask

  task automatic finish_test(input string name, input int err0);
    if (errors == err0) begin
      tests_passed++;
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - err0);
    end
  endtask

  task automatic test_reset_busy();
    int err0;
    int hits0;
    start_test(err0);
    check_flag("reset_busy m_valid", 1'b0, m_valid);
    check_flag("reset_busy busy", 1'b0, busy);
    hits0 = busy_hits;
    add_frame(20, 1'b0);
    drive_input();
    collect_outputs("reset_busy");
    check_flag("reset_busy busy seen", 1'b1, busy_hits > hits0);
    check_flag("reset_busy busy idle", 1'b0, busy);
    finish_test("reset_busy", err0);
  endtask

  task automatic test_short_frame();
    int err0;
    start_test(err0);
    add_frame(3, 1'b0);
    drive_input();
    collect_outputs("short_frame");
    if (got_q.size() > 0) begin
      // icrc occupies bytes 3 to 6
      check_crc("short_frame icrc", last_icrc, got_q[0].data[55:24]);
    end
    finish_test("short_frame", err0);
  endtask

  task automatic test_tail_spill();
    int err0;
    start_test(err0);
    add_frame(24, 1'b0);
    add_frame(22, 1'b0);
    drive_input();
    collect_outputs("tail_spill");
    finish_test("tail_spill", err0);
  endtask

  task automatic test_errored_frame();
    int err0;
    start_test(err0);
    add_frame(13, 1'b1);
    add_frame(5, 1'b0);
    drive_input();
    collect_outputs("errored_frame");
    if (got_q.size() == 4) begin
      // 5 bytes leave three icrc bytes in the last beat and one in the tail
      check_crc("errored_frame icrc", last_icrc, {got_q[3].data[7:0], got_q[2].data[63:40]});
    end
    finish_test("errored_frame", err0);
  endtask

  task automatic test_back_pressure();
    int err0;
    logic [31:0] r;
    start_test(err0);
    stall_en <= 1'b1;
    for (int f = 0; f < 6; f++) begin
      r = next_payload();
      add_frame(1 + int'(r % 32), r[15:8] < 8'd64);
    end
    drive_input();
    collect_outputs("back_pressure");
    stall_en <= 1'b0;
    finish_test("back_pressure", err0);
  endtask

  initial begin
    rst     = 1'b1;
    s_beat  = '0;
    s_valid = 1'b0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    test_reset_busy();
    test_short_frame();
    test_tail_spill();
    test_errored_frame();
    test_back_pressure();
    $display("tests passed %0d failed %0d", tests_passed, tests_failed);
    if (tests_failed == 0 && errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule
